// ==== sources.f ====
mpu_pkg.sv
mpu_req_if.sv
req_queue.sv
pma_lookup.sv
mpu_issue.sv
mpu_top.sv
tb_clock.sv
tb_mpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_mpu
RTL_TOP   ?= mpu_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_mpu.sv ====
// Testbench for the data-side MPU with random traffic, a bus model and a PMA reference model
`timescale 1ns/1ps

module tb_mpu;
  import mpu_pkg::*;

  localparam int          REQ_DEPTH       = 4;
  localparam int          BUS_CREDITS     = 2;
  localparam int          TOTAL_REQS      = 340;
  localparam int          WATCHDOG_CYCLES = TOTAL_REQS * 40 + 16;
  localparam logic [31:0] DM_START        = 32'hF000_0000;
  localparam logic [31:0] DM_END          = 32'hF000_3FFF;
  localparam pma_region_t PMA_TABLE [4]   = PMA_TABLE_DEFAULT;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [1:0]  memtype;
  } bus_item_t;

  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
  } resp_item_t;

  logic        clk, rst_n;
  logic        core_valid_i, core_we_i, core_instr_i, core_dbg_i, core_credit_o;
  logic [31:0] core_addr_i, core_wdata_i, core_resp_rdata_o;
  logic        core_resp_valid_o, core_resp_err_o;
  logic        bus_valid_o, bus_we_o, bus_credit_i, bus_resp_valid_i;
  logic [31:0] bus_addr_o, bus_wdata_o, bus_resp_rdata_i;
  logic [1:0]  bus_memtype_o;

  // Expected outcomes in request order
  bus_item_t   exp_bus [$];
  resp_item_t  exp_resp [$];
  logic [31:0] bus_pending [$];
  logic [31:0] rng = 32'd53859;
  int          core_credits = REQ_DEPTH;
  int          bus_held = BUS_CREDITS;
  int          bus_owed = 0;
  int          reqs_left = 0;
  int          errors = 0;
  logic        mode_dbg = 1'b0;
  logic [2:0]  credit_mask = 3'b001;
  logic        last_bus_resp = 1'b0;

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (.clk_o(clk), .rst_n_o(rst_n));

  mpu_top #(
    .REQ_DEPTH   (REQ_DEPTH),
    .BUS_CREDITS (BUS_CREDITS),
    .NUM_REGIONS (4),
    .PMA_CFG     (PMA_TABLE),
    .DM_START    (DM_START),
    .DM_END      (DM_END)
  ) mpu_top_inst (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Returns {err, cacheable, bufferable} from the first matching region
  function automatic logic [2:0] model_access(input logic [31:0] addr, input logic we,
                                              input logic instr, input logic dbg);
    pma_region_t r;
    logic        found;
    r = PMA_IO_DEFAULT;
    found = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!found && addr[31:2] >= PMA_TABLE[i].word_addr_low &&
          addr[31:2] < PMA_TABLE[i].word_addr_high) begin
        r = PMA_TABLE[i];
        found = 1'b1;
      end
    end
    if (dbg && addr >= DM_START && addr <= DM_END) begin
      r = PMA_DEBUG_ATTR;
    end
    return {!r.main && (instr || addr[1:0] != 2'b00), r.cacheable, r.bufferable && we};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  ////////////////////
  // Output monitor sampled at the falling edge
  ////////////////////
  task automatic monitor();
    bus_item_t  eb;
    resp_item_t er;
    if (core_credit_o) begin
      core_credits++;
    end
    check_value("core credit count ok", 32'(core_credits >= 0 && core_credits <= REQ_DEPTH), 1);
    if (bus_valid_o) begin
      bus_held--;
      bus_owed++;
      bus_pending.push_back(bus_addr_o);
      check_value("bus credit balance ok", 32'(bus_held >= 0), 32'd1);
      if (exp_bus.size() == 0) begin
        $display("Error at %0d ns: a request reached the bus that should be blocked", $time);
        errors++;
      end else begin
        eb = exp_bus.pop_front();
        check_value("bus_addr_o", bus_addr_o, eb.addr);
        check_value("bus_we_o", 32'(bus_we_o), 32'(eb.we));
        check_value("bus_wdata_o", bus_wdata_o, eb.wdata);
        check_value("bus_memtype_o", 32'(bus_memtype_o), 32'(eb.memtype));
      end
    end
    // Bus response must show up on the core side one cycle later
    if (last_bus_resp) begin
      check_value("core_resp_valid_o", 32'(core_resp_valid_o), 32'd1);
    end
    if (core_resp_valid_o) begin
      check_value("core_resp_err_o", 32'(core_resp_err_o), 32'(!last_bus_resp));
      if (exp_resp.size() == 0) begin
        $display("Error at %0d ns: core response with no request waiting for it", $time);
        errors++;
      end else begin
        er = exp_resp.pop_front();
        check_value("core_resp_err_o", 32'(core_resp_err_o), 32'(er.err));
        if (!er.err) begin
          check_value("core_resp_rdata_o", core_resp_rdata_o, er.rdata);
        end
      end
    end
    last_bus_resp = bus_resp_valid_i;
  endtask

  // Bus model returns credits and answers in order with the inverted address
  task automatic drive_bus();
    logic [31:0] r;
    r = next_rand();
    bus_credit_i = 1'b0;
    bus_resp_valid_i = 1'b0;
    if (bus_owed > 0 && (r[2:0] & credit_mask) == 3'b000) begin
      bus_credit_i = 1'b1;
      bus_owed--;
      bus_held++;
    end
    if (bus_pending.size() != 0 && r[8]) begin
      bus_resp_valid_i = 1'b1;
      bus_resp_rdata_i = ~bus_pending.pop_front();
    end
  endtask

  task automatic send_request();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] base;
    logic [2:0]  cls;
    logic [2:0]  outcome;
    bus_item_t   eb;
    resp_item_t  er;
    r = next_rand();
    s = next_rand();
    cls = r[2:0];
    if (mode_dbg) begin
      cls = (r[2:0] == 3'd7) ? 3'd7 : 3'd6;
    end
    case (cls)
      3'd0: base = {16'h0000, r[31:16]};
      3'd1: base = 32'h0001_0000 + {17'h0, r[30:16]};
      3'd2: base = 32'h0001_8000 + {17'h0, r[30:16]};  // Overlap of regions 1 and 3
      3'd3: base = 32'h0002_0000 + {16'h0, r[31:16]};
      3'd4: base = 32'h1000_0000 + {20'h0, r[27:16]};
      3'd5: base = 32'h0800_0000 + {8'h0, r[31:8]};
      3'd6: base = DM_START + {18'h0, r[29:16]};
      default: base = 32'hF000_4000 + {20'h0, r[27:16]};
    endcase
    core_valid_i = 1'b1;
    core_addr_i  = {base[31:2], (s[1:0] == 2'b00) ? s[3:2] : 2'b00};
    core_we_i    = s[4];
    core_instr_i = mode_dbg ? s[5] : (s[7:5] == 3'd0);
    core_dbg_i   = mode_dbg ? s[6] : (s[10:8] == 3'd0);
    core_wdata_i = next_rand();
    outcome = model_access(core_addr_i, core_we_i, core_instr_i, core_dbg_i);
    er.err   = outcome[2];
    er.rdata = ~core_addr_i;
    exp_resp.push_back(er);
    if (!outcome[2]) begin
      eb.addr    = core_addr_i;
      eb.we      = core_we_i;
      eb.wdata   = core_wdata_i;
      eb.memtype = outcome[1:0];
      exp_bus.push_back(eb);
    end
    core_credits--;
    reqs_left--;
  endtask

  // Checks outputs once per clock cycle and drives inputs 1 ns after the edge
  task automatic tick(input logic allow_req);
    logic [31:0] r;
    @(negedge clk);
    monitor();
    @(posedge clk);
    #1;
    drive_bus();
    core_valid_i = 1'b0;
    r = next_rand();
    if (allow_req && reqs_left > 0 && core_credits > 0 && r[1:0] != 2'b00) begin
      send_request();
    end
  endtask

  task automatic run_phase(input string name, input logic dbg, input int count,
                           input logic [2:0] mask);
    int err0;
    err0 = errors;
    mode_dbg = dbg;
    credit_mask = mask;
    reqs_left = count;
    while (reqs_left > 0) begin
      tick(1'b1);
    end
    while (exp_resp.size() != 0) begin
      tick(1'b0);
    end
    tick(1'b0);
    // Every request has left the queue once its response is back
    check_value("core credits returned", 32'(core_credits), 32'(REQ_DEPTH));
    check_value("bus items left", 32'(exp_bus.size()), 32'd0);
    $display("Test %s finished: %0d requests, %0d errors", name, count, errors - err0);
  endtask

  initial begin
    core_valid_i = 1'b0;
    core_addr_i = '0;
    core_we_i = 1'b0;
    core_wdata_i = '0;
    core_instr_i = 1'b0;
    core_dbg_i = 1'b0;
    bus_credit_i = 1'b0;
    bus_resp_valid_i = 1'b0;
    bus_resp_rdata_i = '0;
    wait (rst_n === 1'b1);
    run_phase("mixed", 1'b0, 200, 3'b001);
    run_phase("debug_window", 1'b1, 60, 3'b001);
    // Slow credit return fills the queue and starves the core
    run_phase("backpressure", 1'b0, 80, 3'b111);
    $display("Summary: 3 tests, %0d requests, %0d errors", TOTAL_REQS, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("Timeout: traffic did not drain within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release reset just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// ==== mpu_top.sv ====
// Data-side MPU top level joining the request queue, PMA lookup and issue stage
`timescale 1ns/1ps

module mpu_top #(
  parameter int                   REQ_DEPTH       = 4,
  parameter int                   BUS_CREDITS     = 2,
  parameter int                   MAX_OUTSTANDING = 8,
  parameter int                   NUM_REGIONS     = 4,
  parameter mpu_pkg::pma_region_t PMA_CFG [NUM_REGIONS] = mpu_pkg::PMA_TABLE_DEFAULT,
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_START = 32'hF000_0000,
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_END   = 32'hF000_3FFF
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // Core request port
  input  logic                       core_valid_i,
  input  logic [mpu_pkg::ADDR_W-1:0] core_addr_i,
  input  logic                       core_we_i,
  input  logic [mpu_pkg::DATA_W-1:0] core_wdata_i,
  input  logic                       core_instr_i,
  input  logic                       core_dbg_i,
  output logic                       core_credit_o,

  // Core response port
  output logic                       core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0] core_resp_rdata_o,
  output logic                       core_resp_err_o,

  // Bus request port
  output logic                       bus_valid_o,
  output logic [mpu_pkg::ADDR_W-1:0] bus_addr_o,
  output logic                       bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0] bus_wdata_o,
  output logic [1:0]                 bus_memtype_o,
  input  logic                       bus_credit_i,

  // Bus response port
  input  logic                       bus_resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0] bus_resp_rdata_i
);
  import mpu_pkg::*;

  mpu_req_t core_req;
  logic     pma_err;
  logic     pma_bufferable;
  logic     pma_cacheable;

  assign core_req = '{
    addr:  core_addr_i,
    we:    core_we_i,
    wdata: core_wdata_i,
    instr: core_instr_i,
    dbg:   core_dbg_i
  };

  mpu_req_if req_if ();

  ////////////////////
  // Request queue
  ////////////////////
  req_queue #(
    .REQ_DEPTH (REQ_DEPTH)
  ) u_req_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_valid_i  (core_valid_i),
    .core_req_i    (core_req),
    .core_credit_o (core_credit_o),
    .q             (req_if.queue)
  );

  ////////////////////
  // PMA check on the queue head
  ////////////////////
  pma_lookup #(
    .NUM_REGIONS (NUM_REGIONS),
    .PMA_CFG     (PMA_CFG),
    .DM_START    (DM_START),
    .DM_END      (DM_END)
  ) u_pma_lookup (
    .req_i        (req_if.head),
    .err_o        (pma_err),
    .bufferable_o (pma_bufferable),
    .cacheable_o  (pma_cacheable)
  );

  ////////////////////
  // Issue and response
  ////////////////////
  mpu_issue #(
    .BUS_CREDITS     (BUS_CREDITS),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_mpu_issue (
    .clk               (clk),
    .rst_n             (rst_n),
    .q                 (req_if.issue),
    .pma_err_i         (pma_err),
    .pma_bufferable_i  (pma_bufferable),
    .pma_cacheable_i   (pma_cacheable),
    .bus_valid_o       (bus_valid_o),
    .bus_addr_o        (bus_addr_o),
    .bus_we_o          (bus_we_o),
    .bus_wdata_o       (bus_wdata_o),
    .bus_memtype_o     (bus_memtype_o),
    .bus_credit_i      (bus_credit_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_resp_rdata_i  (bus_resp_rdata_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_rdata_o (core_resp_rdata_o),
    .core_resp_err_o   (core_resp_err_o)
  );

endmodule

// ==== mpu_issue.sv ====
// MPU issue stage with bus credits, outstanding count, error FSM and core response path
`timescale 1ns/1ps

module mpu_issue #(
  parameter int BUS_CREDITS     = 2,
  parameter int MAX_OUTSTANDING = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  mpu_req_if.issue                   q,
  input  logic                       pma_err_i,
  input  logic                       pma_bufferable_i,
  input  logic                       pma_cacheable_i,
  output logic                       bus_valid_o,
  output logic [mpu_pkg::ADDR_W-1:0] bus_addr_o,
  output logic                       bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0] bus_wdata_o,
  output logic [1:0]                 bus_memtype_o,
  input  logic                       bus_credit_i,
  input  logic                       bus_resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0] bus_resp_rdata_i,
  output logic                       core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0] core_resp_rdata_o,
  output logic                       core_resp_err_o
);
  import mpu_pkg::*;

  localparam int CR_W  = $clog2(BUS_CREDITS + 1);
  localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

  mpu_state_e       state_q, state_d;
  logic [CR_W-1:0]  credit_q;
  logic [OUT_W-1:0] outstanding_q;
  logic             head_ok, head_err, issue, err_take, resp_start;

  assign head_ok  = q.head_valid && !pma_err_i;
  assign head_err = !q.queue_empty && pma_err_i;

  // Core side is blocked whenever the FSM is busy with an error
  assign issue    = (state_q == MPU_IDLE) && head_ok && (credit_q != '0) &&
                    (outstanding_q < OUT_W'(MAX_OUTSTANDING));
  assign err_take = (state_q == MPU_IDLE) && head_err;
  assign q.pop    = issue || err_take;

  // Error response starts once the bus side has drained
  assign resp_start = (state_q == MPU_WAIT) && (outstanding_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: if (err_take) state_d = MPU_WAIT;
      MPU_WAIT: if (resp_start) state_d = MPU_RESP;
      default:  state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q           <= MPU_IDLE;
      credit_q          <= CR_W'(BUS_CREDITS);
      outstanding_q     <= '0;
      bus_valid_o       <= 1'b0;
      core_resp_valid_o <= 1'b0;
      core_resp_err_o   <= 1'b0;
    end else begin
      state_q           <= state_d;
      credit_q          <= credit_q + CR_W'(bus_credit_i) - CR_W'(issue);
      outstanding_q     <= outstanding_q + OUT_W'(issue) - OUT_W'(bus_resp_valid_i);
      bus_valid_o       <= issue;
      core_resp_valid_o <= bus_resp_valid_i || resp_start;
      core_resp_err_o   <= resp_start;
    end
  end

  // Bus and response payload
  always_ff @(posedge clk) begin
    if (issue) begin
      bus_addr_o    <= q.head.addr;
      bus_we_o      <= q.head.we;
      bus_wdata_o   <= q.head.wdata;
      bus_memtype_o <= {pma_cacheable_i, pma_bufferable_i};
    end
    if (bus_resp_valid_i) begin
      core_resp_rdata_o <= bus_resp_rdata_i;
    end
  end

endmodule

// ==== pma_lookup.sv ====
// PMA region search with debug window override, giving error and memory-type attributes
`timescale 1ns/1ps

module pma_lookup #(
  parameter int                  NUM_REGIONS = 4,
  parameter mpu_pkg::pma_region_t PMA_CFG [NUM_REGIONS] = '{default: mpu_pkg::PMA_IO_DEFAULT},
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_START = 32'hF000_0000,
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_END   = 32'hF000_3FFF
) (
  input  mpu_pkg::mpu_req_t req_i,
  output logic              err_o,
  output logic              bufferable_o,
  output logic              cacheable_o
);
  import mpu_pkg::*;

  // Regions beyond the supported limit are ignored
  localparam int NREG = (NUM_REGIONS > MAX_REGIONS) ? MAX_REGIONS : NUM_REGIONS;

  logic [WORD_W-1:0] word_addr;
  logic [NREG-1:0]   hit_vec;
  logic              dm_hit;
  logic              misaligned;
  pma_region_t       region_match;
  pma_region_t       region_sel;

  assign word_addr  = req_i.addr[ADDR_W-1:2];
  assign misaligned = |req_i.addr[1:0];

  ////////////////////
  // Region match
  ////////////////////
  for (genvar i = 0; i < NREG; i++) begin : g_hit
    assign hit_vec[i] = (word_addr >= PMA_CFG[i].word_addr_low) &&
                        (word_addr <  PMA_CFG[i].word_addr_high);
  end

  // Walk downwards so the lowest matching index is applied last
  always_comb begin
    region_match = PMA_IO_DEFAULT;
    for (int i = NREG - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        region_match = PMA_CFG[i];
      end
    end
  end

  // Debug window is inclusive at both ends
  assign dm_hit = req_i.dbg && (req_i.addr >= DM_START) && (req_i.addr <= DM_END);

  assign region_sel = dm_hit ? PMA_DEBUG_ATTR : region_match;

  ////////////////////
  // Decision
  ////////////////////

  // Only main memory tolerates fetches and misaligned accesses
  assign err_o = !region_sel.main && (req_i.instr || misaligned);

  // Loads are never marked bufferable
  assign bufferable_o = region_sel.bufferable && req_i.we;
  assign cacheable_o  = region_sel.cacheable;

endmodule

// ==== req_queue.sv ====
// Circular request queue that returns one core credit per entry leaving it
`timescale 1ns/1ps

module req_queue #(
  parameter int REQ_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              core_valid_i,
  input  mpu_pkg::mpu_req_t core_req_i,
  output logic              core_credit_o,
  mpu_req_if.queue          q
);
  import mpu_pkg::*;

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  mpu_req_t   mem [REQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  // Core credits guarantee a free slot, so every valid is written
  assign do_pop = q.pop && q.head_valid;

  assign q.head_valid  = (count_q != '0);
  assign q.queue_empty = (count_q == '0);
  assign q.head        = mem[rd_ptr_q];

  // One returned credit per popped entry
  assign core_credit_o = do_pop;

  // Storage
  always_ff @(posedge clk) begin
    if (core_valid_i) begin
      mem[wr_ptr_q] <= core_req_i;
    end
  end

  ////////////////////
  // Pointers and fill count
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (core_valid_i) begin
        if (wr_ptr_q == PTR_W'(REQ_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + PTR_W'(1);
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == PTR_W'(REQ_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + PTR_W'(1);
        end
      end
      count_q <= count_q + CNT_W'(core_valid_i) - CNT_W'(do_pop);
    end
  end

endmodule

// ==== mpu_req_if.sv ====
// Queue head handshake between the request queue and the MPU issue stage
`timescale 1ns/1ps

interface mpu_req_if;
  import mpu_pkg::*;

  // Head entry and its presence
  logic     head_valid;
  mpu_req_t head;
  logic     queue_empty;

  // Removes the head at the next rising edge
  logic     pop;

  modport queue (
    output head_valid,
    output head,
    output queue_empty,
    input  pop
  );

  modport issue (
    input  head_valid,
    input  head,
    input  queue_empty,
    output pop
  );

endinterface

// ==== mpu_pkg.sv ====
// Shared widths, request and region types, FSM states and the default PMA table of the MPU
package mpu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int WORD_W = ADDR_W - 2;

  // Upper limit on the number of PMA regions
  localparam int MAX_REGIONS = 16;

  // One load or store from the core
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic              instr;
    logic              dbg;
  } mpu_req_t;

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [WORD_W-1:0] word_addr_low;
    logic [WORD_W-1:0] word_addr_high;
    logic              main;
    logic              bufferable;
    logic              cacheable;
  } pma_region_t;

  // Unmatched addresses behave as I/O with no attributes
  localparam pma_region_t PMA_IO_DEFAULT = '{default: '0};

  // Debug module window while in debug mode
  localparam pma_region_t PMA_DEBUG_ATTR = '{main: 1'b1, default: '0};

  // Example table where region 3 overlaps the upper half of region 1
  localparam pma_region_t PMA_TABLE_DEFAULT [4] = '{
    '{word_addr_low: WORD_W'(32'h0000_0000 >> 2), word_addr_high: WORD_W'(32'h0001_0000 >> 2),
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1},
    '{word_addr_low: WORD_W'(32'h0001_0000 >> 2), word_addr_high: WORD_W'(32'h0002_0000 >> 2),
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0},
    '{word_addr_low: WORD_W'(32'h1000_0000 >> 2), word_addr_high: WORD_W'(32'h1000_1000 >> 2),
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    '{word_addr_low: WORD_W'(32'h0001_8000 >> 2), word_addr_high: WORD_W'(32'h0003_0000 >> 2),
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1}
  };

  // Error response sequencing
  typedef enum logic [1:0] {
    MPU_IDLE = 2'd0,
    MPU_WAIT = 2'd1,
    MPU_RESP = 2'd2
  } mpu_state_e;

endpackage
